// File: design/uart_bus_pkg.sv
/*
 * bus side definitions for the uart transmitter
 * widths, transfer codes, base address, register offsets and bit positions
 */
package uart_bus_pkg;

    localparam int bus_addr_width = 32;
    localparam int bus_data_width = 32;
    localparam int trans_width    = 2;

    localparam logic [trans_width-1:0] trans_idle   = 2'b00;
    localparam logic [trans_width-1:0] trans_nonseq = 2'b10;

    localparam logic [bus_addr_width-1:0] uart_base_addr = 32'hC000_0200;

    // offsets from the base address
    localparam logic [bus_addr_width-1:0] data_offset        = 32'd0;
    localparam logic [bus_addr_width-1:0] ctrl_offset        = 32'd4;
    localparam logic [bus_addr_width-1:0] ctrl_set_offset    = 32'd8;
    localparam logic [bus_addr_width-1:0] ctrl_clr_offset    = 32'd12;
    localparam logic [bus_addr_width-1:0] tx_stat_offset     = 32'd16;
    localparam logic [bus_addr_width-1:0] tx_stat_set_offset = 32'd20;
    localparam logic [bus_addr_width-1:0] tx_stat_clr_offset = 32'd24;

    // control register fields, given by their low bit
    localparam int ctrl_data_lsb   = 29;  // 31..29
    localparam int ctrl_parity_lsb = 27;  // 28..27
    localparam int ctrl_stop_lsb   = 25;  // 26..25
    localparam int ctrl_flow_bit   = 24;
    localparam int ctrl_baud_lsb   = 0;   // 23..0

    // tx status register
    localparam int stat_clear_bit    = 31;
    localparam int stat_ovf_ie_bit   = 26;
    localparam int stat_wm_ie_bit    = 25;
    localparam int stat_empty_ie_bit = 24;
    localparam int stat_ovf_bit      = 19;
    localparam int stat_wm_hit_bit   = 18;
    localparam int stat_empty_bit    = 17;
    localparam int stat_full_bit     = 16;
    localparam int stat_wm_lsb       = 8;   // 15..8
    localparam int stat_size_lsb     = 0;   // 7..0

endpackage

// File: design/uart_line_pkg.sv
/*
 * serial line definitions
 * frame format enums, serializer states, queue depth and reset defaults
 */
package uart_line_pkg;

    typedef enum logic [2:0] {
        bits_5 = 3'd0,
        bits_6 = 3'd1,
        bits_7 = 3'd2,
        bits_8 = 3'd3,
        bits_9 = 3'd4
    } data_bits_e;

    typedef enum logic [1:0] {
        parity_none = 2'd0,
        parity_odd  = 2'd1,
        parity_even = 2'd2   // 3 is not a valid code
    } parity_e;

    typedef enum logic [1:0] {
        stop_1 = 2'd0,
        stop_2 = 2'd2        // 1 and 3 rejected
    } stop_bits_e;

    typedef enum logic [2:0] {st_idle, st_start, st_data, st_parity, st_stop} tx_state_e;

    localparam int baud_width      = 24;
    localparam int char_width      = 9;
    localparam int fifo_addr_width = 4;   // 16 entries
    localparam int count_width     = fifo_addr_width + 1;

    localparam logic [baud_width-1:0]  default_baud         = 24'd3333;
    localparam logic [count_width-1:0] default_tx_watermark = '0;

endpackage

// File: design/uart_reg_file.sv
/*
 * bus slave with control and tx status registers
 * set and clear aliases, field sanitizing, sticky overflow, interrupt gating
 */
`timescale 1ns/1ps

module uart_reg_file (
    input  logic                                    clk,
    input  logic                                    n_reset,
    input  logic [uart_bus_pkg::bus_addr_width-1:0] haddr,
    input  logic                                    hwrite,
    input  logic [uart_bus_pkg::trans_width-1:0]    htrans,
    input  logic [uart_bus_pkg::bus_data_width-1:0] hwdata,
    output logic [uart_bus_pkg::bus_data_width-1:0] hrdata,
    output logic                                    hready,
    output logic                                    hresp,
    output logic                                    push,
    output logic                                    flush,
    output logic [uart_line_pkg::char_width-1:0]    push_data,
    input  logic [uart_line_pkg::count_width-1:0]   size,
    input  logic                                    empty,
    input  logic                                    full,
    input  logic                                    overflow,
    output uart_line_pkg::data_bits_e               data_bits,
    output uart_line_pkg::parity_e                  parity,
    output uart_line_pkg::stop_bits_e               stop_bits,
    output logic                                    flow_ctrl,
    output logic [uart_line_pkg::baud_width-1:0]    baud,
    output logic                                    int_any,
    output logic                                    int_tx_empty,
    output logic                                    int_tx_watermark_reached,
    output logic                                    int_tx_overflow_error
);

    logic [uart_bus_pkg::bus_addr_width-1:0] haddr_q;
    logic                                    hwrite_q;
    logic [uart_bus_pkg::trans_width-1:0]    htrans_q;
    logic [uart_bus_pkg::bus_addr_width-1:0] wr_offset;   // data phase
    logic [uart_bus_pkg::bus_addr_width-1:0] rd_offset;   // address phase
    logic                                    wr_active;
    logic [uart_bus_pkg::bus_data_width-1:0] ctrl_rd, ctrl_req, stat_rd, stat_req;
    logic [2:0]                              req_bits;
    logic [1:0]                              req_parity, req_stop;
    logic                                    ovf_ie, wm_ie, empty_ie, ovf_flag, wm_reached;
    logic [uart_line_pkg::count_width-1:0]   watermark;

    // plain write, or or-in / mask-out through the aliases
    function automatic logic [uart_bus_pkg::bus_data_width-1:0] merge(
        input logic [uart_bus_pkg::bus_data_width-1:0] cur,
        input logic [uart_bus_pkg::bus_data_width-1:0] wdata,
        input logic                                    set_sel,
        input logic                                    clr_sel
    );
        if (set_sel)
            return wdata | cur;
        if (clr_sel)
            return ~wdata & cur;
        return wdata;
    endfunction

    assign hready    = 1'b1;
    assign hresp     = 1'b0;  // always OKAY
    assign wr_offset = haddr_q - uart_bus_pkg::uart_base_addr;
    assign rd_offset = haddr - uart_bus_pkg::uart_base_addr;
    assign wr_active = hwrite_q && htrans_q == uart_bus_pkg::trans_nonseq;

    assign push      = wr_active && wr_offset == uart_bus_pkg::data_offset;
    assign push_data = hwdata[uart_line_pkg::char_width-1:0];

    assign ctrl_rd = {data_bits, parity, stop_bits, flow_ctrl, baud};

    always_comb begin
        stat_rd = '0;
        stat_rd[uart_bus_pkg::stat_clear_bit]    = flush;
        stat_rd[uart_bus_pkg::stat_ovf_ie_bit]   = ovf_ie;
        stat_rd[uart_bus_pkg::stat_wm_ie_bit]    = wm_ie;
        stat_rd[uart_bus_pkg::stat_empty_ie_bit] = empty_ie;
        stat_rd[uart_bus_pkg::stat_ovf_bit]      = ovf_flag;
        stat_rd[uart_bus_pkg::stat_wm_hit_bit]   = wm_reached;
        stat_rd[uart_bus_pkg::stat_empty_bit]    = empty;
        stat_rd[uart_bus_pkg::stat_full_bit]     = full;
        stat_rd[uart_bus_pkg::stat_wm_lsb +: uart_line_pkg::count_width]   = watermark;
        stat_rd[uart_bus_pkg::stat_size_lsb +: uart_line_pkg::count_width] = size;
    end

    assign ctrl_req = merge(ctrl_rd, hwdata, wr_offset == uart_bus_pkg::ctrl_set_offset,
                            wr_offset == uart_bus_pkg::ctrl_clr_offset);
    assign stat_req = merge(stat_rd, hwdata, wr_offset == uart_bus_pkg::tx_stat_set_offset,
                            wr_offset == uart_bus_pkg::tx_stat_clr_offset);

    assign req_bits   = ctrl_req[uart_bus_pkg::ctrl_data_lsb +: 3];
    assign req_parity = ctrl_req[uart_bus_pkg::ctrl_parity_lsb +: 2];
    assign req_stop   = ctrl_req[uart_bus_pkg::ctrl_stop_lsb +: 2];

    assign wm_reached = size <= watermark;

    assign int_tx_empty             = empty && empty_ie;
    assign int_tx_watermark_reached = wm_reached && wm_ie;
    assign int_tx_overflow_error    = ovf_flag && ovf_ie;
    assign int_any = int_tx_empty || int_tx_watermark_reached || int_tx_overflow_error;

    // address phase capture and read data
    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            haddr_q  <= '0;
            hwrite_q <= 1'b0;
            htrans_q <= uart_bus_pkg::trans_idle;
            hrdata   <= '0;
        end else begin
            haddr_q  <= haddr;
            hwrite_q <= hwrite;
            htrans_q <= htrans;
            if (htrans == uart_bus_pkg::trans_nonseq && !hwrite) begin
                case (rd_offset)
                    uart_bus_pkg::ctrl_offset:    hrdata <= ctrl_rd;
                    uart_bus_pkg::tx_stat_offset: hrdata <= stat_rd;
                    default:                      hrdata <= '0;  // data and aliases read zero
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            data_bits <= uart_line_pkg::bits_8;
            parity    <= uart_line_pkg::parity_none;
            stop_bits <= uart_line_pkg::stop_1;
            flow_ctrl <= 1'b0;
            baud      <= uart_line_pkg::default_baud;
            watermark <= uart_line_pkg::default_tx_watermark;
            flush     <= 1'b0;
            ovf_ie    <= 1'b0;
            wm_ie     <= 1'b0;
            empty_ie  <= 1'b0;
            ovf_flag  <= 1'b0;
        end else begin
            flush    <= 1'b0;                  // self clearing
            ovf_flag <= ovf_flag || overflow;  // sticky until written
            if (wr_active) begin
                case (wr_offset)
                    uart_bus_pkg::ctrl_offset,
                    uart_bus_pkg::ctrl_set_offset,
                    uart_bus_pkg::ctrl_clr_offset: begin
                        if (req_bits >= uart_line_pkg::bits_9) begin
                            // 9 bits leave no room for parity or a second stop bit
                            data_bits <= uart_line_pkg::bits_9;
                            parity    <= uart_line_pkg::parity_none;
                            stop_bits <= uart_line_pkg::stop_1;
                        end else begin
                            data_bits <= uart_line_pkg::data_bits_e'(req_bits);
                            if (req_parity != 2'd3)
                                parity <= uart_line_pkg::parity_e'(req_parity);
                            if (!req_stop[0])  // codes 1 and 3 ignored
                                stop_bits <= uart_line_pkg::stop_bits_e'(req_stop);
                        end
                        flow_ctrl <= ctrl_req[uart_bus_pkg::ctrl_flow_bit];
                        baud      <= ctrl_req[uart_bus_pkg::ctrl_baud_lsb +: uart_line_pkg::baud_width];
                    end
                    uart_bus_pkg::tx_stat_offset,
                    uart_bus_pkg::tx_stat_set_offset,
                    uart_bus_pkg::tx_stat_clr_offset: begin
                        flush     <= stat_req[uart_bus_pkg::stat_clear_bit];
                        ovf_ie    <= stat_req[uart_bus_pkg::stat_ovf_ie_bit];
                        wm_ie     <= stat_req[uart_bus_pkg::stat_wm_ie_bit];
                        empty_ie  <= stat_req[uart_bus_pkg::stat_empty_ie_bit];
                        ovf_flag  <= stat_req[uart_bus_pkg::stat_ovf_bit] || overflow;
                        watermark <= stat_req[uart_bus_pkg::stat_wm_lsb +: uart_line_pkg::count_width];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: design/uart_tx_fifo.sv
/*
 * transmit queue, 16 characters deep
 * fill count, flush and overflow pulse on a push into a full queue
 */
`timescale 1ns/1ps

module uart_tx_fifo (
    input  logic                                  clk,
    input  logic                                  n_reset,
    input  logic                                  push,
    input  logic                                  pop,
    input  logic                                  flush,
    input  logic [uart_line_pkg::char_width-1:0]  push_data,
    output logic [uart_line_pkg::char_width-1:0]  head,
    output logic [uart_line_pkg::count_width-1:0] size,
    output logic                                  empty,
    output logic                                  full,
    output logic                                  overflow
);

    logic [uart_line_pkg::char_width-1:0]      mem [0:(1 << uart_line_pkg::fifo_addr_width)-1];
    logic [uart_line_pkg::fifo_addr_width-1:0] wr_ptr, rd_ptr;
    logic                                      do_push, do_pop;

    assign empty    = size == '0;
    assign full     = size == uart_line_pkg::count_width'(1 << uart_line_pkg::fifo_addr_width);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign overflow = push && full;   // the push itself is dropped
    assign head     = mem[rd_ptr];

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            size   <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            size   <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at 16
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                size <= size + 1'b1;
            else if (do_pop && !do_push)
                size <= size - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush)
            mem[wr_ptr] <= push_data;
    end

endmodule

// File: design/uart_tx_serializer.sv
/*
 * frame FSM for the tx line
 * start bit, 5 to 9 data bits lsb first, optional parity, one or two stop bits
 */
`timescale 1ns/1ps

module uart_tx_serializer (
    input  logic                                 clk,
    input  logic                                 n_reset,
    input  logic [uart_line_pkg::char_width-1:0] head,
    input  logic                                 empty,
    output logic                                 pop,
    input  uart_line_pkg::data_bits_e            data_bits,
    input  uart_line_pkg::parity_e               parity,
    input  uart_line_pkg::stop_bits_e            stop_bits,
    input  logic                                 flow_ctrl,
    input  logic                                 cts,
    input  logic [uart_line_pkg::baud_width-1:0] baud,
    output logic                                 tx
);

    uart_line_pkg::tx_state_e             state;
    logic [uart_line_pkg::char_width-1:0] shift_q;
    logic [uart_line_pkg::baud_width-1:0] baud_q, baud_cnt;
    logic [3:0]                           nbits_q, bit_cnt;
    uart_line_pkg::parity_e               parity_q;
    uart_line_pkg::stop_bits_e            stop_q;
    logic                                 par_acc;  // running xor of sent data bits
    logic                                 bit_done, send_data;

    // cts only matters between frames
    assign pop       = state == uart_line_pkg::st_idle && !empty && (!flow_ctrl || !cts);
    assign bit_done  = baud_cnt == baud_q - 1'b1;
    assign send_data = state == uart_line_pkg::st_start ||
                       (state == uart_line_pkg::st_data && bit_cnt != nbits_q);

    // frame payload, taken at pop
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_q  <= head;
            baud_q   <= baud;
            nbits_q  <= 4'(data_bits) + 4'd5;  // enum code 0 is 5 bits
            parity_q <= parity;
            stop_q   <= stop_bits;
        end else if (bit_done && send_data) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            state    <= uart_line_pkg::st_idle;
            tx       <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            par_acc  <= 1'b0;
        end else if (state == uart_line_pkg::st_idle) begin
            if (pop) begin
                state    <= uart_line_pkg::st_start;
                tx       <= 1'b0;
                baud_cnt <= '0;
                bit_cnt  <= '0;
                par_acc  <= 1'b0;
            end
        end else if (!bit_done) begin
            baud_cnt <= baud_cnt + 1'b1;
        end else begin
            baud_cnt <= '0;
            if (send_data) begin
                tx      <= shift_q[0];
                par_acc <= par_acc ^ shift_q[0];
                bit_cnt <= bit_cnt + 1'b1;
                state   <= uart_line_pkg::st_data;
            end else begin
                case (state)
                    uart_line_pkg::st_data: begin
                        if (parity_q != uart_line_pkg::parity_none) begin
                            // odd parity inverts the xor
                            tx    <= par_acc ^ (parity_q == uart_line_pkg::parity_odd);
                            state <= uart_line_pkg::st_parity;
                        end else begin
                            tx      <= 1'b1;
                            bit_cnt <= '0;
                            state   <= uart_line_pkg::st_stop;
                        end
                    end
                    uart_line_pkg::st_parity: begin
                        tx      <= 1'b1;
                        bit_cnt <= '0;
                        state   <= uart_line_pkg::st_stop;
                    end
                    uart_line_pkg::st_stop: begin
                        if (stop_q == uart_line_pkg::stop_2 && bit_cnt == '0)
                            bit_cnt <= 4'd1;  // second stop bit
                        else
                            state <= uart_line_pkg::st_idle;
                    end
                    default: state <= uart_line_pkg::st_idle;
                endcase
            end
        end
    end

endmodule

// File: design/uart_tx_top.sv
/*
 * uart transmitter top level
 * register file feeding the tx queue, queue feeding the serializer
 */
`timescale 1ns/1ps

module uart_tx_top (
    input  logic                                    clk,
    input  logic                                    n_reset,
    input  logic [uart_bus_pkg::bus_addr_width-1:0] haddr,
    input  logic                                    hwrite,
    input  logic [uart_bus_pkg::trans_width-1:0]    htrans,
    input  logic [uart_bus_pkg::bus_data_width-1:0] hwdata,
    output logic [uart_bus_pkg::bus_data_width-1:0] hrdata,
    output logic                                    hready,
    output logic                                    hresp,
    input  logic                                    cts,
    output logic                                    tx,
    output logic                                    int_any,
    output logic                                    int_tx_empty,
    output logic                                    int_tx_watermark_reached,
    output logic                                    int_tx_overflow_error
);

    logic                                  push, pop, flush;
    logic                                  empty, full, overflow;
    logic [uart_line_pkg::char_width-1:0]  push_data, head;
    logic [uart_line_pkg::count_width-1:0] size;
    uart_line_pkg::data_bits_e             data_bits;
    uart_line_pkg::parity_e                parity;
    uart_line_pkg::stop_bits_e             stop_bits;
    logic                                  flow_ctrl;
    logic [uart_line_pkg::baud_width-1:0]  baud;

    uart_reg_file u_reg_file (
        .clk(clk), .n_reset(n_reset),
        .haddr(haddr), .hwrite(hwrite), .htrans(htrans), .hwdata(hwdata),
        .hrdata(hrdata), .hready(hready), .hresp(hresp),
        .push(push), .flush(flush), .push_data(push_data),
        .size(size), .empty(empty), .full(full), .overflow(overflow),
        .data_bits(data_bits), .parity(parity), .stop_bits(stop_bits),
        .flow_ctrl(flow_ctrl), .baud(baud),
        .int_any(int_any), .int_tx_empty(int_tx_empty),
        .int_tx_watermark_reached(int_tx_watermark_reached),
        .int_tx_overflow_error(int_tx_overflow_error)
    );

    uart_tx_fifo u_tx_fifo (
        .clk(clk), .n_reset(n_reset),
        .push(push), .pop(pop), .flush(flush), .push_data(push_data),
        .head(head), .size(size), .empty(empty), .full(full), .overflow(overflow)
    );

    uart_tx_serializer u_tx_serializer (
        .clk(clk), .n_reset(n_reset),
        .head(head), .empty(empty), .pop(pop),
        .data_bits(data_bits), .parity(parity), .stop_bits(stop_bits),
        .flow_ctrl(flow_ctrl), .cts(cts), .baud(baud), .tx(tx)
    );

endmodule

// File: verif/tb_uart_tx.sv
/*
 * trace driven testbench for the uart transmitter
 * bus driver, line monitor, interrupt and register checks
 */
`timescale 1ns/1ps

module tb_uart_tx;

    localparam string trace_file = "verif/uart_tx_trace.txt";
    localparam int    max_tests  = 256;
    localparam logic [31:0] data_addr = uart_bus_pkg::uart_base_addr + uart_bus_pkg::data_offset;
    localparam logic [31:0] ctrl_addr = uart_bus_pkg::uart_base_addr + uart_bus_pkg::ctrl_offset;

    logic                                    clk, n_reset, hwrite, cts;
    logic [uart_bus_pkg::bus_addr_width-1:0] haddr;
    logic [uart_bus_pkg::trans_width-1:0]    htrans;
    logic [uart_bus_pkg::bus_data_width-1:0] hwdata, hrdata;
    logic                                    hready, hresp, tx;
    logic int_any, int_tx_empty, int_tx_watermark_reached, int_tx_overflow_error;

    string       t_name [0:max_tests-1];
    string       t_op   [0:max_tests-1];
    logic [31:0] t_arg1 [0:max_tests-1];
    logic [31:0] t_arg2 [0:max_tests-1];
    int          n_tests, value_errors, other_errors, cycles, cycle_limit;
    bit          limit_set;
    logic [31:0] lcg_state;

    int          line_bits, line_par, line_stops, line_baud;  // format of the last ctrl write
    logic [22:0] rx_q [$];  // {format, stop level, parity bit, character}
    logic [8:0]  mon_char;
    logic        mon_par, mon_stop;
    logic [11:0] mon_fmt;
    int          mon_bits, mon_baud;

    uart_tx_top dut (
        .clk(clk), .n_reset(n_reset),
        .haddr(haddr), .hwrite(hwrite), .htrans(htrans), .hwdata(hwdata),
        .hrdata(hrdata), .hready(hready), .hresp(hresp),
        .cts(cts), .tx(tx), .int_any(int_any), .int_tx_empty(int_tx_empty),
        .int_tx_watermark_reached(int_tx_watermark_reached),
        .int_tx_overflow_error(int_tx_overflow_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return (s * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
    endfunction

    // parity bit a correct frame carries for this character and format
    function automatic logic expected_parity(input logic [8:0] ch, input int nbits, input int ptype);
        logic p;
        p = 1'b0;
        for (int i = 0; i < nbits; i++)
            p = p ^ ch[i];
        if (ptype == 1)
            return ~p;  // odd
        if (ptype == 2)
            return p;
        return 1'b0;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            value_errors++;
            $display("error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        haddr  = addr;
        hwrite = 1'b1;
        htrans = uart_bus_pkg::trans_nonseq;
        @(posedge clk);
        #2;
        hwrite = 1'b0;
        htrans = uart_bus_pkg::trans_idle;
        hwdata = data;  // data phase
        @(posedge clk);
        #2;
        if (addr == ctrl_addr) begin
            line_bits  = data[31:29] + 5;
            line_par   = data[28:27];
            line_stops = (data[26:25] == 2'd2) ? 2 : 1;
            line_baud  = data[23:0];
        end
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        haddr  = addr;
        hwrite = 1'b0;
        htrans = uart_bus_pkg::trans_nonseq;
        @(posedge clk);
        #2;
        htrans = uart_bus_pkg::trans_idle;
        data   = hrdata;  // registered at the edge that ended the address phase
    endtask

    task automatic load_trace();
        int          fd, n, max_baud;
        string       line, name, op;
        logic [31:0] a1, a2;
        n_tests  = 0;
        max_baud = 1;
        fd = $fopen(trace_file, "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the trace file %s", trace_file);
        end else begin
            while (!$feof(fd) && n_tests < max_tests) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h", name, op, a1, a2);
                    if (n == 4) begin
                        t_name[n_tests] = name;
                        t_op[n_tests]   = op;
                        t_arg1[n_tests] = a1;
                        t_arg2[n_tests] = a2;
                        n_tests++;
                        if (op == "wr" && a1 == ctrl_addr && a2[23:0] > max_baud)
                            max_baud = a2[23:0];
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = n_tests * 12 * max_baud + 1000;  // longest frame per trace line
        limit_set   = 1'b1;
    endtask

    task automatic run_test(input int k);
        logic [31:0] got;
        logic [22:0] rx;
        int          nb, pt;
        if (t_op[k] == "wr") begin
            bus_write(t_arg1[k], t_arg2[k]);
        end else if (t_op[k] == "rd") begin
            bus_read(t_arg1[k], got);
            compare_value(t_name[k], t_arg2[k], got);
            compare_value(t_name[k], 32'd2, {30'd0, hready, hresp});  // ready, OKAY
        end else if (t_op[k] == "frame") begin
            while (rx_q.size() == 0) begin
                @(posedge clk);
                #2;
            end
            rx = rx_q.pop_front();
            nb = t_arg2[k][11:8];
            pt = t_arg2[k][7:4];
            compare_value(t_name[k], t_arg2[k][11:0], rx[22:11]);  // format the monitor used
            compare_value(t_name[k], t_arg1[k][8:0], rx[8:0]);
            compare_value(t_name[k], expected_parity(t_arg1[k][8:0], nb, pt), rx[9]);
            compare_value(t_name[k], 1, rx[10]);  // all stop bits high
        end else if (t_op[k] == "cts") begin
            cts = t_arg1[k][0];
        end else if (t_op[k] == "wait") begin
            repeat (t_arg1[k]) @(posedge clk);
            #2;
        end else if (t_op[k] == "fill") begin
            for (int i = 0; i < t_arg1[k]; i++) begin
                lcg_state = lcg_next(lcg_state);
                bus_write(data_addr, {23'd0, lcg_state[24:16]});
            end
        end else if (t_op[k] == "irq") begin
            compare_value(t_name[k], t_arg1[k], {28'd0, int_any, int_tx_empty,
                          int_tx_watermark_reached, int_tx_overflow_error});
        end else begin
            other_errors++;
            $display("unknown opcode %s in test %s", t_op[k], t_name[k]);
        end
    endtask

    // line monitor, samples each bit at its middle on the falling clock
    initial begin
        forever begin
            @(negedge clk);
            if (n_reset === 1'b1 && tx === 1'b0) begin
                mon_bits = line_bits;
                mon_baud = line_baud;
                mon_fmt  = {4'(line_bits), 4'(line_par), 4'(line_stops)};
                mon_char = '0;
                mon_par  = 1'b0;
                mon_stop = 1'b1;
                repeat (mon_baud / 2) @(negedge clk);  // middle of the start bit
                for (int i = 0; i < mon_bits; i++) begin
                    repeat (mon_baud) @(negedge clk);
                    mon_char[i] = tx;
                end
                if (mon_fmt[7:4] != 0) begin
                    repeat (mon_baud) @(negedge clk);
                    mon_par = tx;
                end
                for (int i = 0; i < mon_fmt[3:0]; i++) begin
                    repeat (mon_baud) @(negedge clk);
                    mon_stop = mon_stop & tx;
                end
                rx_q.push_back({mon_fmt, mon_stop, mon_par, mon_char});
            end
        end
    end

    initial begin
        wait (limit_set);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the trace did not finish within %0d cycles", cycle_limit);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors + 1);
        $display("tests failed");
        $finish;
    end

    initial begin
        haddr        = '0;
        hwrite       = 1'b0;
        htrans       = uart_bus_pkg::trans_idle;
        hwdata       = '0;
        cts          = 1'b0;
        n_reset      = 1'b0;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        lcg_state    = 32'd48829;
        line_bits    = 8;
        line_par     = 0;
        line_stops   = 1;
        line_baud    = 3333;
        load_trace();
        repeat (5) @(posedge clk);
        #2 n_reset = 1'b1;
        @(posedge clk);
        #2;
        assert (n_tests > 0) else begin
            other_errors++;
            $display("the trace holds no tests");
        end
        for (int k = 0; k < n_tests; k++)
            run_test(k);
        assert (rx_q.size() == 0) else begin
            other_errors++;
            $display("%0d frames were sent on tx that no test expected", rx_q.size());
        end
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: verif/uart_tx_trace.txt
# columns: test name, opcode, first argument (hex), second argument (hex)
# wr addr data | rd addr expected | frame char format(bits parity stops) | cts level | wait cycles | fill count | irq {any empty wm ovf}
reset_ctrl rd C0000204 60000D05
reset_stat rd C0000210 00060000
ctrl_set_flow wr C0000208 01000000
ctrl_set_flow rd C0000204 61000D05
ctrl_clr_flow wr C000020C 01000000
ctrl_clr_flow rd C0000204 60000D05
stat_set_wm wr C0000214 00000300
stat_set_wm rd C0000210 00060300
stat_clr_wm wr C0000218 00000100
stat_clr_wm rd C0000210 00060200
data_read rd C0000200 00000000
sanitize_9e2 wr C0000204 94000008
sanitize_9e2 rd C0000204 80000008
keep_parity wr C0000204 50000008
keep_parity wr C0000204 58000008
keep_parity rd C0000204 50000008
keep_stop wr C0000204 52000008
keep_stop rd C0000204 50000008
keep_stop3 wr C0000204 54000008
keep_stop3 wr C0000204 56000008
keep_stop3 rd C0000204 54000008
frame_8n1 wr C0000204 60000008
frame_8n1 wr C0000200 000000A5
frame_8n1 wr C0000200 0000003C
frame_8n1 frame 000000A5 00000801
frame_8n1 frame 0000003C 00000801
frame_7e2 wr C0000204 54000008
frame_7e2 wr C0000200 0000005B
frame_7e2 frame 0000005B 00000722
frame_9n1 wr C0000204 80000008
frame_9n1 wr C0000200 000001C3
frame_9n1 frame 000001C3 00000901
frame_5o1 wr C0000204 08000008
frame_5o1 wr C0000200 00000016
frame_5o1 frame 00000016 00000511
queue_block cts 1 0
queue_block wr C0000204 61000008
queue_block wr C0000210 00000400
queue_fill fill 10 0
queue_fill rd C0000210 00010410
queue_ovf fill 1 0
queue_ovf rd C0000210 00090410
queue_irq wr C0000214 07000000
queue_irq irq 9 0
flow_hold wait 64 0
flow_hold rd C0000210 07090410
flush wr C0000214 80000000
flush wait 2 0
flush rd C0000210 070E0400
flush irq F 0
ovf_clear wr C0000218 00080000
ovf_clear rd C0000210 07060400
ovf_clear irq E 0
after_flush cts 0 0
after_flush wait 28 0
after_flush wr C0000200 00000077
after_flush frame 00000077 00000801

// File: verilog.f
design/uart_bus_pkg.sv
design/uart_line_pkg.sv
design/uart_reg_file.sv
design/uart_tx_fifo.sv
design/uart_tx_serializer.sv
design/uart_tx_top.sv
verif/tb_uart_tx.sv

// File: Bender.yml
package:
  name: uart_tx

sources:
  - design/uart_bus_pkg.sv
  - design/uart_line_pkg.sv
  - design/uart_reg_file.sv
  - design/uart_tx_fifo.sv
  - design/uart_tx_serializer.sv
  - design/uart_tx_top.sv
  - target: simulation
    files:
      - verif/tb_uart_tx.sv
